// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the single-port test memory testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=test_mem_1port_tb
BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"
rm -f "$LOG"

# Compile the sources from the file list into a simulation binary
verilator --binary --timing -Wno-fatal \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Run and keep a log
"./$BUILD_DIR/V$TOP" 2>&1 | tee "$LOG"
run_status=${PIPESTATUS[0]}
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# The verdict is the pass line in the log
if grep -qxF "** PASS **" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

// ==== sim.f ====
source/mem_msg_pkg.sv
source/mem_queue_1entry.sv
source/mem_req_handler.sv
source/test_mem_1port.sv
verification/test_mem_1port_tb.sv

// ==== source/mem_msg_pkg.sv ====
/*
 * Memory message definitions for the single-port test memory
 * Type codes, field width typedefs, request and response structs
 */

`default_nettype none

package mem_msg_pkg;

  // --------------------------------------------------
  // Field widths
  // --------------------------------------------------

  // Request and response type code
  typedef logic [2:0]  mem_type_t;

  // Opaque tag, echoed back untouched
  typedef logic [7:0]  mem_opaque_t;

  // Byte address, upper bits past the array size are ignored
  typedef logic [31:0] mem_addr_t;

  // Byte count, zero encodes a full word
  typedef logic [1:0]  mem_len_t;

  // One data word
  typedef logic [31:0] mem_data_t;

  // Bytes per data word
  localparam int MEM_DATA_NBYTES = 4;

  // --------------------------------------------------
  // Type codes
  // --------------------------------------------------

  localparam mem_type_t MEM_READ       = 3'd0;
  localparam mem_type_t MEM_WRITE      = 3'd1;
  localparam mem_type_t MEM_WRITE_INIT = 3'd2;
  localparam mem_type_t MEM_AMO_ADD    = 3'd3;
  localparam mem_type_t MEM_AMO_AND    = 3'd4;
  localparam mem_type_t MEM_AMO_OR     = 3'd5;

  // --------------------------------------------------
  // Messages
  // --------------------------------------------------

  // Request, 77 bits, type in the top bits
  typedef struct packed {
    mem_type_t   type_;
    mem_opaque_t opaque;
    mem_addr_t   addr;
    mem_len_t    len;
    mem_data_t   data;
  } mem_req_msg_t;

  // Response, 45 bits, no address field
  typedef struct packed {
    mem_type_t   type_;
    mem_opaque_t opaque;
    mem_len_t    len;
    mem_data_t   data;
  } mem_resp_msg_t;

endpackage

`default_nettype wire

// ==== source/mem_queue_1entry.sv ====
/*
 * One-entry valid/ready queue
 * Pipe mode registers every message, bypass mode passes through when empty
 */

`timescale 1ns/1ps
`default_nettype none

module mem_queue_1entry #(
  parameter bit  p_bypass = 1'b0,
  parameter type p_msg_t  = logic [7:0]
) (
  input  wire logic clk,
  input  wire logic reset,

  // Enqueue side
  input  wire logic enq_val_i,
  output logic      enq_rdy_o,
  input  p_msg_t    enq_msg_i,

  // Dequeue side
  output logic      deq_val_o,
  input  wire logic deq_rdy_i,
  output p_msg_t    deq_msg_o
);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Occupancy of the single slot
  logic   full;

  // Held message, payload only
  p_msg_t entry;

  logic   enq_fire;
  logic   deq_fire;
  logic   store_en;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------

  // Pipe also accepts while full if the entry leaves this cycle
  // Bypass only accepts into an empty slot
  assign enq_rdy_o = p_bypass ? !full : (!full || deq_rdy_i);

  // Bypass shows the incoming message while empty
  assign deq_val_o = p_bypass ? (full || enq_val_i) : full;
  assign deq_msg_o = (p_bypass && !full) ? enq_msg_i : entry;

  assign enq_fire  = enq_val_i && enq_rdy_o;
  assign deq_fire  = deq_val_o && deq_rdy_i;

  // Pipe stores every accepted message
  // Bypass stores only when the pass-through is not taken
  assign store_en  = p_bypass ? (enq_fire && !deq_rdy_i) : enq_fire;

  // --------------------------------------------------
  // State update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset) begin
      full <= 1'b0;
    end else if (store_en) begin
      // Also covers pipe enqueue and dequeue on the same edge
      full <= 1'b1;
    end else if (deq_fire) begin
      full <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (store_en) begin
      entry <= enq_msg_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_req_handler.sv ====
/*
 * Request handler of the test memory
 * Word array, address decode, byte-lane writes, atomics, clear
 * and response packing
 */

`timescale 1ns/1ps
`default_nettype none

module mem_req_handler #(
  parameter int p_mem_nbytes = 1024
) (
  input  wire logic                    clk,

  // Zeroes the whole array on the next edge
  input  wire logic                    mem_clear_i,

  // Request from the pipe queue
  input  wire logic                    req_val_i,
  input  wire logic                    req_go_i,
  input  mem_msg_pkg::mem_req_msg_t    req_msg_i,

  // Response toward the bypass queue
  output mem_msg_pkg::mem_resp_msg_t   resp_msg_o
);

  import mem_msg_pkg::*;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------

  localparam int c_addr_nbits = $clog2(p_mem_nbytes);
  localparam int c_num_words  = p_mem_nbytes / MEM_DATA_NBYTES;

  // Physical byte address, word index and byte offset
  typedef logic [c_addr_nbits-1:0] phys_addr_t;
  typedef logic [c_addr_nbits-3:0] word_idx_t;
  typedef logic [1:0]              byte_off_t;

  // Byte count with room for a full word
  typedef logic [2:0]              byte_cnt_t;

  mem_data_t  mem_array [c_num_words];

  phys_addr_t phys_addr;
  word_idx_t  word_idx;
  byte_off_t  offset;
  byte_cnt_t  len_bytes;

  mem_data_t  rd_word;
  mem_data_t  rd_data;
  mem_data_t  wr_shifted;
  mem_data_t  wr_word;
  mem_data_t  amo_word;
  mem_data_t  next_word;

  logic       is_write;
  logic       is_amo;
  logic       commit_en;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  // Drop address bits above the array size
  assign phys_addr = req_msg_i.addr[c_addr_nbits-1:0];
  assign word_idx  = phys_addr[c_addr_nbits-1:2];
  assign offset    = phys_addr[1:0];

  // Zero length means a full word
  assign len_bytes = (req_msg_i.len == '0) ? byte_cnt_t'(MEM_DATA_NBYTES)
                                            : {1'b0, req_msg_i.len};

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------

  assign rd_word = mem_array[word_idx];

  // Shift the addressed byte down to lane 0, upper bytes fill with zero
  assign rd_data = rd_word >> {offset, 3'b000};

  // --------------------------------------------------
  // Write and atomic data
  // --------------------------------------------------

  assign is_write = (req_msg_i.type_ == MEM_WRITE) ||
                    (req_msg_i.type_ == MEM_WRITE_INIT);
  assign is_amo   = (req_msg_i.type_ == MEM_AMO_ADD) ||
                    (req_msg_i.type_ == MEM_AMO_AND) ||
                    (req_msg_i.type_ == MEM_AMO_OR);

  // Request byte 0 lines up with the offset lane
  assign wr_shifted = req_msg_i.data << {offset, 3'b000};

  // Replace only the lanes covered by offset and length
  // Bytes past the word end simply have no lane
  always_comb begin
    wr_word = rd_word;
    for (int i = 0; i < MEM_DATA_NBYTES; i++) begin
      if ((i >= offset) && (i < offset + len_bytes)) begin
        wr_word[i*8 +: 8] = wr_shifted[i*8 +: 8];
      end
    end
  end

  // Atomics work on the whole word, offset ignored
  always_comb begin
    case (req_msg_i.type_)
      MEM_AMO_ADD: amo_word = rd_word + req_msg_i.data;
      MEM_AMO_AND: amo_word = rd_word & req_msg_i.data;
      MEM_AMO_OR:  amo_word = rd_word | req_msg_i.data;
      default:     amo_word = rd_word;
    endcase
  end

  assign next_word = is_amo ? amo_word : wr_word;

  // Commit once, on the edge where the response is taken
  assign commit_en = req_val_i && req_go_i && (is_write || is_amo);

  // --------------------------------------------------
  // Array update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (mem_clear_i) begin
      // Clear wins over any commit on the same edge
      for (int w = 0; w < c_num_words; w++) begin
        mem_array[w] <= '0;
      end
    end else if (commit_en) begin
      mem_array[word_idx] <= next_word;
    end
  end

  // --------------------------------------------------
  // Response packing
  // --------------------------------------------------

  always_comb begin
    resp_msg_o.type_  = req_msg_i.type_;
    resp_msg_o.opaque = req_msg_i.opaque;
    resp_msg_o.len    = req_msg_i.len;
    if (req_msg_i.type_ == MEM_READ) begin
      resp_msg_o.data = rd_data;
    end else if (is_amo) begin
      // Old word, before the combine
      resp_msg_o.data = rd_word;
    end else begin
      resp_msg_o.data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/test_mem_1port.sv ====
/*
 * Single-port test memory top level
 * Pipe request queue, request handler, bypass response queue
 */

`timescale 1ns/1ps
`default_nettype none

module test_mem_1port #(
  parameter int p_mem_nbytes = 1024
) (
  input  wire logic                   clk,
  input  wire logic                   reset,

  // Zeroes the memory contents
  input  wire logic                   mem_clear_i,

  // Request port
  input  wire logic                   memreq_val_i,
  output logic                        memreq_rdy_o,
  input  mem_msg_pkg::mem_req_msg_t   memreq_msg_i,

  // Response port
  output logic                        memresp_val_o,
  input  wire logic                   memresp_rdy_i,
  output mem_msg_pkg::mem_resp_msg_t  memresp_msg_o
);

  import mem_msg_pkg::*;

  // Registered request in front of the handler
  logic          req_val;
  logic          req_go;
  mem_req_msg_t  req_msg;

  // Response built from the current request
  mem_resp_msg_t resp_msg;

  // --------------------------------------------------
  // Request queue, registers the input
  // --------------------------------------------------

  mem_queue_1entry #(
    .p_bypass (1'b0),
    .p_msg_t  (mem_req_msg_t)
  ) req_queue (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (memreq_val_i),
    .enq_rdy_o (memreq_rdy_o),
    .enq_msg_i (memreq_msg_i),
    .deq_val_o (req_val),
    // Request leaves exactly when its response enters
    .deq_rdy_i (req_go),
    .deq_msg_o (req_msg)
  );

  // --------------------------------------------------
  // Storage and request execution
  // --------------------------------------------------

  mem_req_handler #(
    .p_mem_nbytes (p_mem_nbytes)
  ) req_handler (
    .clk         (clk),
    .mem_clear_i (mem_clear_i),
    .req_val_i   (req_val),
    .req_go_i    (req_go),
    .req_msg_i   (req_msg),
    .resp_msg_o  (resp_msg)
  );

  // --------------------------------------------------
  // Response queue, same-cycle pass-through when empty
  // --------------------------------------------------

  mem_queue_1entry #(
    .p_bypass (1'b1),
    .p_msg_t  (mem_resp_msg_t)
  ) resp_queue (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (req_val),
    .enq_rdy_o (req_go),
    .enq_msg_i (resp_msg),
    .deq_val_o (memresp_val_o),
    .deq_rdy_i (memresp_rdy_i),
    .deq_msg_o (memresp_msg_o)
  );

endmodule

`default_nettype wire

// ==== verification/test_mem_1port_tb.sv ====
/*
 * Testbench for the single-port test memory
 * Clock and reset, random requests, response back-pressure,
 * reference memory model, in-order scoreboard and watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module test_mem_1port_tb;

  import mem_msg_pkg::*;

  // --------------------------------------------------
  // Test sizes
  // --------------------------------------------------

  localparam int c_mem_nbytes = 1024;
  localparam int c_num_words  = c_mem_nbytes / MEM_DATA_NBYTES;
  localparam int c_idx_bits   = $clog2(c_num_words);
  localparam int c_clk_half   = 4;

  // Requests per phase
  // The fill and the read after the clear each cover every word
  localparam int c_full_reqs    = 150;
  localparam int c_partial_reqs = 300;
  localparam int c_atomic_reqs  = 200;
  localparam int c_stall_reqs   = 300;
  localparam int c_timing_reqs  = 100;
  localparam int c_total_reqs   = 2 * c_num_words + c_full_reqs + c_partial_reqs +
                                  c_atomic_reqs + c_stall_reqs + c_timing_reqs;

  logic          clk;
  logic          reset;
  logic          mem_clear_i;
  logic          memreq_val_i;
  logic          memreq_rdy_o;
  mem_req_msg_t  memreq_msg_i;
  logic          memresp_val_o;
  logic          memresp_rdy_i;
  mem_resp_msg_t memresp_msg_o;

  // Reference contents and owed responses in request order
  mem_data_t     model_mem [c_num_words];
  mem_resp_msg_t exp_queue [$];
  int            accept_cycle_q [$];

  integer        seed;
  int            error_count;
  int            check_count;
  int            cycle_count;
  mem_opaque_t   next_opaque;
  logic          backpressure;
  logic          latency_check;
  logic          saw_req_stall;
  string         test_name;

  test_mem_1port #(
    .p_mem_nbytes (c_mem_nbytes)
  ) test_mem_1port_inst (
    .clk           (clk),
    .reset         (reset),
    .mem_clear_i   (mem_clear_i),
    .memreq_val_i  (memreq_val_i),
    .memreq_rdy_o  (memreq_rdy_o),
    .memreq_msg_i  (memreq_msg_i),
    .memresp_val_o (memresp_val_o),
    .memresp_rdy_i (memresp_rdy_i),
    .memresp_msg_o (memresp_msg_o)
  );

  initial begin
    clk = 1'b0;
    forever #c_clk_half clk = ~clk;
  end

  // --------------------------------------------------
  // Checking and reference model
  // --------------------------------------------------

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[FAIL] %s %s: expected %08h, actual %08h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic clear_model();
    for (int w = 0; w < c_num_words; w++) begin
      model_mem[w] = '0;
    end
  endtask

  // Apply one accepted request and queue the response it owes
  task automatic accept_request(input mem_req_msg_t msg);
    mem_resp_msg_t exp;
    mem_data_t     word;
    int            idx;
    int            off;
    int            nbytes;
    // Address bits past the array size alias onto the same word
    idx        = int'((msg.addr % c_mem_nbytes) / MEM_DATA_NBYTES);
    off        = int'(msg.addr % MEM_DATA_NBYTES);
    nbytes     = (msg.len == '0) ? MEM_DATA_NBYTES : int'(msg.len);
    word       = model_mem[idx];
    exp.type_  = msg.type_;
    exp.opaque = msg.opaque;
    exp.len    = msg.len;
    exp.data   = '0;
    case (msg.type_)
      MEM_READ: exp.data = word >> (8 * off);
      MEM_WRITE, MEM_WRITE_INIT: begin
        // Bytes that run past the word end are lost
        for (int b = 0; b < nbytes; b++) begin
          if (off + b < MEM_DATA_NBYTES) begin
            word[(off + b) * 8 +: 8] = msg.data[b * 8 +: 8];
          end
        end
      end
      MEM_AMO_ADD: begin
        exp.data = word;
        word     = word + msg.data;
      end
      MEM_AMO_AND: begin
        exp.data = word;
        word     = word & msg.data;
      end
      MEM_AMO_OR: begin
        exp.data = word;
        word     = word | msg.data;
      end
      default: ;
    endcase
    model_mem[idx] = word;
    exp_queue.push_back(exp);
    accept_cycle_q.push_back(cycle_count);
  endtask

  task automatic take_response();
    mem_resp_msg_t exp;
    int            acc_cycle;
    if (exp_queue.size() == 0) begin
      error_count++;
      $display("%s: response with opaque %02h arrived with no request outstanding",
               test_name, memresp_msg_o.opaque);
    end else begin
      exp       = exp_queue.pop_front();
      acc_cycle = accept_cycle_q.pop_front();
      check_value("type", 32'(exp.type_), 32'(memresp_msg_o.type_));
      check_value("opaque", 32'(exp.opaque), 32'(memresp_msg_o.opaque));
      check_value("len", 32'(exp.len), 32'(memresp_msg_o.len));
      check_value("data", exp.data, memresp_msg_o.data);
      if (latency_check) begin
        check_value("response latency", 1, 32'(cycle_count - acc_cycle));
      end
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  // One clock cycle with inputs changed on the falling edge
  task automatic step_cycle(input logic req_val, input mem_req_msg_t req_msg,
                            output logic accepted);
    @(negedge clk);
    memreq_val_i  = req_val;
    memreq_msg_i  = req_msg;
    // Ready low about 40% of the time
    memresp_rdy_i = backpressure ? (({$random(seed)} % 10) >= 4) : 1'b1;
    // Outputs settle here and hold until the rising edge
    #1;
    accepted = memreq_val_i && memreq_rdy_o;
    if (!memreq_rdy_o) begin
      saw_req_stall = 1'b1;
    end
    // A response taken now belongs to an older request
    if (memresp_val_o && memresp_rdy_i) begin
      take_response();
    end
    if (accepted) begin
      accept_request(memreq_msg_i);
    end
    cycle_count++;
  endtask

  // Message stays on the port until taken
  task automatic send_request(input mem_req_msg_t msg, output int tries);
    logic accepted;
    tries    = 0;
    accepted = 1'b0;
    while (!accepted) begin
      step_cycle(1'b1, msg, accepted);
      tries++;
    end
  endtask

  task automatic drain_responses();
    logic accepted;
    while (exp_queue.size() != 0) begin
      step_cycle(1'b0, '0, accepted);
    end
  endtask

  // Mode 0 gives full aligned words
  // Mode 1 adds partial accesses and mode 2 adds atomics
  task automatic random_request(input int mode, input int span,
                                output mem_req_msg_t msg);
    mem_addr_t addr;
    int        pick;
    // Upper address bits stay random for aliasing
    addr                 = $random(seed);
    addr[c_idx_bits+1:2] = c_idx_bits'({$random(seed)} % span);
    pick = (mode == 2) ? int'({$random(seed)} % 6) : int'({$random(seed)} % 3);
    msg.type_  = mem_type_t'(pick);
    msg.opaque = next_opaque;
    msg.data   = $random(seed);
    msg.len    = mem_len_t'($random(seed));
    if (mode == 0) begin
      addr[1:0] = 2'b00;
      msg.len   = '0;
    end
    msg.addr    = addr;
    next_opaque = next_opaque + 8'd1;
  endtask

  // Pattern built from every bit of the byte address
  function automatic mem_data_t fill_pattern(input int byte_addr);
    mem_addr_t a;
    a = mem_addr_t'(byte_addr);
    return {~a[15:0], a[15:0]};
  endfunction

  // Nonzero contents for the clear to erase
  task automatic fill_all_words();
    mem_req_msg_t msg;
    int           tries;
    test_name = "fill";
    for (int w = 0; w < c_num_words; w++) begin
      msg         = '0;
      msg.type_   = MEM_WRITE_INIT;
      msg.opaque  = next_opaque;
      msg.addr    = mem_addr_t'(w * MEM_DATA_NBYTES);
      msg.data    = fill_pattern(w * MEM_DATA_NBYTES);
      next_opaque = next_opaque + 8'd1;
      send_request(msg, tries);
    end
    drain_responses();
  endtask

  task automatic read_all_words();
    mem_req_msg_t msg;
    int           tries;
    test_name = "clear_read";
    for (int w = 0; w < c_num_words; w++) begin
      msg         = '0;
      msg.type_   = MEM_READ;
      msg.opaque  = next_opaque;
      msg.addr    = mem_addr_t'(w * MEM_DATA_NBYTES);
      next_opaque = next_opaque + 8'd1;
      send_request(msg, tries);
    end
    drain_responses();
  endtask

  task automatic run_phase(input string name, input int count, input int mode,
                           input int span);
    mem_req_msg_t msg;
    int           tries;
    test_name = name;
    for (int n = 0; n < count; n++) begin
      random_request(mode, span, msg);
      send_request(msg, tries);
      // Full throughput means every request goes in on its first cycle
      if (latency_check) begin
        check_value("accept cycles", 1, 32'(tries));
      end
    end
    drain_responses();
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin : main
    reset         = 1'b0;
    mem_clear_i   = 1'b0;
    memreq_val_i  = 1'b0;
    memreq_msg_i  = '0;
    memresp_rdy_i = 1'b1;
    seed          = 5;
    error_count   = 0;
    check_count   = 0;
    cycle_count   = 0;
    next_opaque   = '0;
    backpressure  = 1'b0;
    latency_check = 1'b0;
    saw_req_stall = 1'b0;
    test_name     = "reset";
    repeat (10) @(negedge clk);
    reset = 1'b1;
    fill_all_words();
    // One-cycle clear with no request on the port
    @(negedge clk);
    mem_clear_i = 1'b1;
    @(negedge clk);
    mem_clear_i = 1'b0;
    clear_model();
    read_all_words();
    run_phase("full_word", c_full_reqs, 0, 16);
    run_phase("partial", c_partial_reqs, 1, 16);
    run_phase("atomic", c_atomic_reqs, 2, 8);
    backpressure  = 1'b1;
    saw_req_stall = 1'b0;
    run_phase("backpressure", c_stall_reqs, 2, 32);
    check_value("request stall seen", 1, 32'(saw_req_stall));
    backpressure  = 1'b0;
    latency_check = 1'b1;
    run_phase("timing", c_timing_reqs, 2, 32);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Budget of 20 cycles per request plus setup
  initial begin : watchdog
    repeat (c_total_reqs * 20 + 200) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles",
             c_total_reqs * 20 + 200);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
